//--- hdl/melee_pkg.sv
package melee_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [11:0] pos_t;
    typedef logic [11:0] rgb_t;
    typedef logic [2:0]  step_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        SWING,
        RECOVER
    } ctrl_state_t;

    // Tiny raster, so one frame is only 80 by 56 clocks.
    localparam coord_t H_VISIBLE    = 11'd64;
    localparam coord_t H_TOTAL      = 11'd80;
    localparam coord_t H_SYNC_START = 11'd68;
    localparam coord_t H_SYNC_END   = 11'd72;
    localparam coord_t V_VISIBLE    = 11'd48;
    localparam coord_t V_TOTAL      = 11'd56;
    localparam coord_t V_SYNC_START = 11'd50;
    localparam coord_t V_SYNC_END   = 11'd52;

    localparam pos_t IMG_WIDTH  = 12'd8;
    localparam pos_t IMG_HEIGHT = 12'd6;
    localparam int   ROM_DEPTH  = IMG_WIDTH * IMG_HEIGHT;
    localparam int   ROM_AW     = $clog2(ROM_DEPTH);

    localparam rgb_t TRANSPARENT_RGB = 12'h02F;
    localparam rgb_t BG_RGB_A        = 12'h236;
    localparam rgb_t BG_RGB_B        = 12'h348;

    localparam step_cnt_t FRAMES_PER_STEP = 3'd2;
    localparam step_cnt_t SWING_STEPS     = 3'd4;
    localparam pos_t      ANIM_STEP       = 12'd3;
    localparam step_cnt_t COOLDOWN_STEPS  = 3'd2;
    localparam pos_t      ANIM_MAX        = ANIM_STEP * pos_t'(SWING_STEPS - 3'd1);
    localparam int        DRAW_LATENCY    = 3;

endpackage

//--- hdl/vga_if.sv
`timescale 1ns/1ps

interface vga_if;
    import melee_pkg::*;

    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

//--- hdl/vga_raster.sv
`timescale 1ns/1ps

module vga_raster (
    input  logic clk,
    input  logic rst,
    output logic frame_start,
    vga_if.out   raster
);
    import melee_pkg::*;

    coord_t h_nxt;
    coord_t v_nxt;
    logic   visible_nxt;

    // All flags are computed from the next count so they line up with the counters.
    always_comb begin
        h_nxt = raster.hcount + 11'd1;
        v_nxt = raster.vcount;
        if (raster.hcount == H_TOTAL - 11'd1) begin
            h_nxt = '0;
            v_nxt = (raster.vcount == V_TOTAL - 11'd1) ? '0 : raster.vcount + 11'd1;
        end
    end

    assign visible_nxt = (h_nxt < H_VISIBLE) && (v_nxt < V_VISIBLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            raster.hcount <= '0;
            raster.vcount <= '0;
            raster.hsync  <= 1'b0;
            raster.vsync  <= 1'b0;
            raster.hblnk  <= 1'b0;
            raster.vblnk  <= 1'b0;
            raster.rgb    <= '0;
            frame_start   <= 1'b0;
        end else begin
            raster.hcount <= h_nxt;
            raster.vcount <= v_nxt;
            raster.hsync  <= (h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_END);
            raster.vsync  <= (v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_END);
            raster.hblnk  <= (h_nxt >= H_VISIBLE);
            raster.vblnk  <= (v_nxt >= V_VISIBLE);
            // Stripes are four pixels wide.
            if (visible_nxt) begin
                raster.rgb <= h_nxt[2] ? BG_RGB_B : BG_RGB_A;
            end else begin
                raster.rgb <= '0;
            end
            frame_start <= (v_nxt == V_VISIBLE) && (h_nxt == '0);
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (raster.hcount < H_TOTAL) && (raster.vcount < V_TOTAL));

endmodule

//--- hdl/frame_timer.sv
`timescale 1ns/1ps

module frame_timer (
    input  logic clk,
    input  logic rst,
    input  logic frame_start,
    input  logic run,
    output logic step
);
    import melee_pkg::*;

    step_cnt_t frame_cnt;
    logic      last_frame;

    assign last_frame = (frame_cnt == FRAMES_PER_STEP - 3'd1);
    assign step       = run && frame_start && last_frame;

    // The count sits at zero while stopped, so a new run starts a full step.
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= last_frame ? '0 : frame_cnt + 3'd1;
        end
    end

endmodule

//--- hdl/attack_ctrl.sv
`timescale 1ns/1ps

module attack_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           attack,
    input  logic           frame_start,
    input  logic           step,
    output logic           timer_run,
    output logic           wpn_active,
    output logic           busy,
    output melee_pkg::pos_t anim_offset
);
    import melee_pkg::*;

    ctrl_state_t state;
    logic        pending;
    step_cnt_t   step_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            pending     <= 1'b0;
            step_cnt    <= '0;
            anim_offset <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // The swing waits for blanking so it never starts mid-frame.
                    if (frame_start && pending) begin
                        state       <= SWING;
                        pending     <= 1'b0;
                        step_cnt    <= '0;
                        anim_offset <= '0;
                    end else if (attack) begin
                        pending <= 1'b1;
                    end
                end
                SWING: begin
                    if (step) begin
                        if (step_cnt == SWING_STEPS - 3'd1) begin
                            state       <= RECOVER;
                            step_cnt    <= '0;
                            anim_offset <= '0;
                        end else begin
                            step_cnt    <= step_cnt + 3'd1;
                            anim_offset <= anim_offset + ANIM_STEP;
                        end
                    end
                end
                RECOVER: begin
                    if (step) begin
                        if (step_cnt == COOLDOWN_STEPS - 3'd1) begin
                            state    <= IDLE;
                            step_cnt <= '0;
                        end else begin
                            step_cnt <= step_cnt + 3'd1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign timer_run  = (state != IDLE);
    assign wpn_active = (state == SWING);
    assign busy       = (state != IDLE) || pending;

    a_offset_max: assert property (@(posedge clk) disable iff (rst)
        anim_offset <= ANIM_MAX);

    // State only moves in the cycle after a frame start, which is in blanking.
    a_change_in_blank: assert property (@(posedge clk) disable iff (rst)
        (state != $past(state)) |-> $past(frame_start));

endmodule

//--- hdl/wpn_draw_melee.sv
`timescale 1ns/1ps

module wpn_draw_melee (
    input  logic            clk,
    input  logic            rst,
    input  logic            wpn_active,
    input  logic            flip_h,
    input  melee_pkg::pos_t pos_x,
    input  melee_pkg::pos_t pos_y,
    input  melee_pkg::pos_t anim_offset,
    vga_if.in               vga_in,
    vga_if.out              vga_out
);
    import melee_pkg::*;

    rgb_t sprite_rom [ROM_DEPTH];

    initial $readmemh("hdl/wpn_sprite.dat", sprite_rom);

    pos_t   box_left;
    pos_t   box_top;
    pos_t   rel_x;
    pos_t   rel_y;
    pos_t   col;
    pos_t   rom_addr;
    rgb_t   rom_rgb;
    rgb_t   rgb_nxt;
    logic   in_box;

    coord_t hcount_d1, hcount_d2;
    coord_t vcount_d1, vcount_d2;
    logic   hsync_d1, hsync_d2;
    logic   vsync_d1, vsync_d2;
    logic   hblnk_d1, hblnk_d2;
    logic   vblnk_d1, vblnk_d2;
    rgb_t   rgb_d1, rgb_d2;

    // A flipped weapon swings to the left.
    assign box_left = flip_h ? pos_x - anim_offset - (IMG_WIDTH >> 1)
                             : pos_x + anim_offset - (IMG_WIDTH >> 1);
    assign box_top  = pos_y - (IMG_HEIGHT >> 1);

    // Pixels left of or above the box wrap to large values and fail the range test.
    assign rel_x    = {1'b0, vga_in.hcount} - box_left;
    assign rel_y    = {1'b0, vga_in.vcount} - box_top;
    assign in_box   = (rel_x < IMG_WIDTH) && (rel_y < IMG_HEIGHT);
    assign col      = flip_h ? (IMG_WIDTH - 12'd1 - rel_x) : rel_x;
    assign rom_addr = rel_y * IMG_WIDTH + col;
    assign rom_rgb  = sprite_rom[rom_addr[ROM_AW-1:0]];

    always_comb begin
        rgb_nxt = vga_in.rgb;
        if (wpn_active && !vga_in.hblnk && !vga_in.vblnk && in_box &&
            rom_rgb != TRANSPARENT_RGB) begin
            rgb_nxt = rom_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_d1 <= '0;
            vcount_d1 <= '0;
            hsync_d1  <= 1'b0;
            vsync_d1  <= 1'b0;
            hblnk_d1  <= 1'b0;
            vblnk_d1  <= 1'b0;
            rgb_d1    <= '0;
            hcount_d2 <= '0;
            vcount_d2 <= '0;
            hsync_d2  <= 1'b0;
            vsync_d2  <= 1'b0;
            hblnk_d2  <= 1'b0;
            vblnk_d2  <= 1'b0;
            rgb_d2    <= '0;
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            hcount_d1 <= vga_in.hcount;
            vcount_d1 <= vga_in.vcount;
            hsync_d1  <= vga_in.hsync;
            vsync_d1  <= vga_in.vsync;
            hblnk_d1  <= vga_in.hblnk;
            vblnk_d1  <= vga_in.vblnk;
            rgb_d1    <= rgb_nxt;
            hcount_d2 <= hcount_d1;
            vcount_d2 <= vcount_d1;
            hsync_d2  <= hsync_d1;
            vsync_d2  <= vsync_d1;
            hblnk_d2  <= hblnk_d1;
            vblnk_d2  <= vblnk_d1;
            rgb_d2    <= rgb_d1;
            vga_out.hcount <= hcount_d2;
            vga_out.vcount <= vcount_d2;
            vga_out.hsync  <= hsync_d2;
            vga_out.vsync  <= vsync_d2;
            vga_out.hblnk  <= hblnk_d2;
            vga_out.vblnk  <= vblnk_d2;
            vga_out.rgb    <= rgb_d2;
        end
    end

endmodule

//--- hdl/melee_top.sv
`timescale 1ns/1ps

module melee_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              attack,
    input  logic              flip_h,
    input  melee_pkg::pos_t   pos_x,
    input  melee_pkg::pos_t   pos_y,
    output melee_pkg::coord_t hcount,
    output melee_pkg::coord_t vcount,
    output logic              hsync,
    output logic              vsync,
    output logic              hblnk,
    output logic              vblnk,
    output logic              busy,
    output melee_pkg::rgb_t   rgb
);
    import melee_pkg::*;

    logic frame_start;
    logic timer_run;
    logic step;
    logic wpn_active;
    pos_t anim_offset;

    vga_if raster_bus ();
    vga_if video_bus ();

    vga_raster u_vga_raster (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .raster      (raster_bus)
    );

    frame_timer u_frame_timer (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .run         (timer_run),
        .step        (step)
    );

    attack_ctrl u_attack_ctrl (
        .clk         (clk),
        .rst         (rst),
        .attack      (attack),
        .frame_start (frame_start),
        .step        (step),
        .timer_run   (timer_run),
        .wpn_active  (wpn_active),
        .busy        (busy),
        .anim_offset (anim_offset)
    );

    wpn_draw_melee u_wpn_draw_melee (
        .clk         (clk),
        .rst         (rst),
        .wpn_active  (wpn_active),
        .flip_h      (flip_h),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .anim_offset (anim_offset),
        .vga_in      (raster_bus),
        .vga_out     (video_bus)
    );

    assign hcount = video_bus.hcount;
    assign vcount = video_bus.vcount;
    assign hsync  = video_bus.hsync;
    assign vsync  = video_bus.vsync;
    assign hblnk  = video_bus.hblnk;
    assign vblnk  = video_bus.vblnk;
    assign rgb    = video_bus.rgb;

endmodule

//--- verification/melee_tb.sv
`timescale 1ns/1ps

module melee_tb;
    import melee_pkg::*;

    localparam int NUM_ATTACKS  = 12;
    localparam int CLK_PERIOD   = 10;
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    // Wait for the pending start, the swing, the cooldown and the random idle gap.
    localparam int FRAMES_PER_ATTACK = 2 + 1 +
        (int'(SWING_STEPS) + int'(COOLDOWN_STEPS)) * int'(FRAMES_PER_STEP);
    localparam int MARGIN_FRAMES = 6;
    localparam longint WATCHDOG_NS = longint'(NUM_ATTACKS * FRAMES_PER_ATTACK + MARGIN_FRAMES)
        * FRAME_CYCLES * CLK_PERIOD;
    localparam int X_MIN = int'(IMG_WIDTH) / 2 + int'(ANIM_MAX);
    localparam int X_MAX = int'(H_VISIBLE) - int'(IMG_WIDTH) / 2 - int'(ANIM_MAX);
    localparam int Y_MIN = int'(IMG_HEIGHT) / 2;
    localparam int Y_MAX = int'(V_VISIBLE) - int'(IMG_HEIGHT) / 2;

    logic   clk;
    logic   rst;
    logic   attack;
    logic   flip_h;
    pos_t   pos_x;
    pos_t   pos_y;
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    logic   busy;
    rgb_t   rgb;

    rgb_t                    sprite [ROM_DEPTH];
    int unsigned             lcg_state;
    ctrl_state_t             model_state;
    logic                    model_pending;
    int                      model_frames;
    int                      model_steps;
    int                      model_offset;
    int                      model_swings;
    int                      drawn_swings;
    logic                    sprite_in_frame;
    logic                    sprite_prev_frame;
    logic [DRAW_LATENCY:0]   attack_hist;
    logic [DRAW_LATENCY-1:0] busy_hist;
    logic                    vblnk_prev;
    logic                    checking;
    int                      prev_h;
    int                      prev_v;

    melee_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .attack (attack),
        .flip_h (flip_h),
        .pos_x  (pos_x),
        .pos_y  (pos_y),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .busy   (busy),
        .rgb    (rgb)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial $readmemh("hdl/wpn_sprite.dat", sprite);

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    task automatic report_error(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // Background stripes, with the sprite on top while the model is in its swing.
    function automatic rgb_t expected_rgb(int h, int v);
        int   left;
        int   top;
        int   col;
        int   row;
        rgb_t bg;
        rgb_t color;
        if (h >= int'(H_VISIBLE) || v >= int'(V_VISIBLE)) begin
            return '0;
        end
        bg = ((h % 8) >= 4) ? BG_RGB_B : BG_RGB_A;
        if (model_state != SWING) begin
            return bg;
        end
        if (flip_h) begin
            left = int'(pos_x) - model_offset - int'(IMG_WIDTH) / 2;
        end else begin
            left = int'(pos_x) + model_offset - int'(IMG_WIDTH) / 2;
        end
        top = int'(pos_y) - int'(IMG_HEIGHT) / 2;
        col = h - left;
        row = v - top;
        if (col < 0 || col >= int'(IMG_WIDTH) || row < 0 || row >= int'(IMG_HEIGHT)) begin
            return bg;
        end
        if (flip_h) begin
            col = int'(IMG_WIDTH) - 1 - col;
        end
        color = sprite[row * int'(IMG_WIDTH) + col];
        return (color == TRANSPARENT_RGB) ? bg : color;
    endfunction

    task automatic advance_model(logic fs, logic atk);
        logic step_now;
        step_now = (model_state != IDLE) && fs &&
                   (model_frames == int'(FRAMES_PER_STEP) - 1);
        if (model_state == IDLE) begin
            model_frames = 0;
        end else if (fs) begin
            model_frames = step_now ? 0 : model_frames + 1;
        end
        case (model_state)
            IDLE: begin
                if (fs && model_pending) begin
                    model_state   = SWING;
                    model_pending = 1'b0;
                    model_steps   = 0;
                    model_offset  = 0;
                    model_swings++;
                end else if (atk) begin
                    model_pending = 1'b1;
                end
            end
            SWING: begin
                if (step_now) begin
                    model_steps++;
                    if (model_steps == int'(SWING_STEPS)) begin
                        model_state = RECOVER;
                        model_steps = 0;
                    end else begin
                        model_offset += int'(ANIM_STEP);
                    end
                end
            end
            default: begin
                if (step_now) begin
                    model_steps++;
                    if (model_steps == int'(COOLDOWN_STEPS)) begin
                        model_state = IDLE;
                        model_steps = 0;
                    end
                end
            end
        endcase
    endtask

    // The model runs on the output time line, three clocks behind the attack input.
    task automatic check_cycle();
        logic fs;
        int   h;
        int   v;
        int   exp_h;
        int   exp_v;
        rgb_t exp_rgb;
        h  = int'(hcount);
        v  = int'(vcount);
        fs = vblnk && !vblnk_prev;
        attack_hist = {attack_hist[DRAW_LATENCY-1:0], attack};
        busy_hist   = {busy_hist[DRAW_LATENCY-2:0], busy};
        if (fs) begin
            checking = 1'b1;
        end
        if (checking) begin
            exp_h = (prev_h + 1) % int'(H_TOTAL);
            exp_v = (exp_h == 0) ? (prev_v + 1) % int'(V_TOTAL) : prev_v;
            assert (h == exp_h && v == exp_v) else report_error($sformatf(
                "counters are (%0d,%0d), expected (%0d,%0d)", h, v, exp_h, exp_v));
            assert (hsync == (h >= int'(H_SYNC_START) && h < int'(H_SYNC_END)))
                else report_error($sformatf("hsync is %b at hcount %0d", hsync, h));
            assert (vsync == (v >= int'(V_SYNC_START) && v < int'(V_SYNC_END)))
                else report_error($sformatf("vsync is %b at vcount %0d", vsync, v));
            assert (hblnk == (h >= int'(H_VISIBLE)) && vblnk == (v >= int'(V_VISIBLE)))
                else report_error($sformatf("blanking is %b/%b at (%0d,%0d)",
                    hblnk, vblnk, h, v));
            exp_rgb = expected_rgb(h, v);
            assert (rgb == exp_rgb) else report_error($sformatf(
                "rgb at (%0d,%0d) is %h, expected %h", h, v, rgb, exp_rgb));
            if (!hblnk && !vblnk && rgb != (hcount[2] ? BG_RGB_B : BG_RGB_A)) begin
                sprite_in_frame = 1'b1;
            end
        end
        if (fs) begin
            if (sprite_in_frame && !sprite_prev_frame) begin
                drawn_swings++;
            end
            sprite_prev_frame = sprite_in_frame;
            sprite_in_frame   = 1'b0;
        end
        advance_model(fs, attack_hist[DRAW_LATENCY]);
        if (checking) begin
            assert (busy_hist[DRAW_LATENCY-1] == (model_state != IDLE || model_pending))
                else report_error($sformatf("busy is %b, model state %s pending %b",
                    busy_hist[DRAW_LATENCY-1], model_state.name(), model_pending));
        end
        prev_h     = h;
        prev_v     = v;
        vblnk_prev = vblnk;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            model_state       = IDLE;
            model_pending     = 1'b0;
            model_frames      = 0;
            model_steps       = 0;
            model_offset      = 0;
            model_swings      = 0;
            drawn_swings      = 0;
            sprite_in_frame   = 1'b0;
            sprite_prev_frame = 1'b0;
            attack_hist       = '0;
            busy_hist         = '0;
            vblnk_prev        = 1'b0;
            checking          = 1'b0;
            prev_h            = 0;
            prev_v            = 0;
        end else begin
            check_cycle();
        end
    end

    task automatic wait_frames(int n);
        repeat (n) begin
            @(posedge vblnk);
        end
        #1;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int unsigned gap;
        lcg_state = 74;
        rst       = 1'b1;
        attack    = 1'b0;
        flip_h    = 1'b0;
        pos_x     = pos_t'(X_MIN);
        pos_y     = pos_t'(Y_MIN);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // A few idle frames first, with nothing drawn over the stripes.
        wait_frames(2);
        for (int a = 0; a < NUM_ATTACKS; a++) begin
            wait_idle();
            gap = lcg_next() % FRAME_CYCLES;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            pos_x  = pos_t'(X_MIN + int'(lcg_next() % (X_MAX - X_MIN + 1)));
            pos_y  = pos_t'(Y_MIN + int'(lcg_next() % (Y_MAX - Y_MIN + 1)));
            flip_h = (lcg_next() % 2) == 1;
            @(posedge clk);
            #1;
            attack = 1'b1;
            @(posedge clk);
            #1;
            attack = 1'b0;
            // Stray strobes while the swing is pending or running.
            while (busy) begin
                @(posedge clk);
                #1;
                attack = busy && ((lcg_next() % 4000) == 0);
            end
        end
        wait_frames(2);
        assert (drawn_swings == model_swings) else report_error($sformatf(
            "%0d swings drawn, model expects %0d", drawn_swings, model_swings));
        assert (model_swings == NUM_ATTACKS) else report_error($sformatf(
            "model counted %0d swings, expected %0d", model_swings, NUM_ATTACKS));
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish in the expected number of frames");
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- hdl/wpn_sprite.dat
// One 12-bit RGB color in hex per line, row by row, 8 columns by 6 rows.
02F
02F
02F
02F
02F
02F
FFF
CCD
02F
02F
02F
02F
02F
CCD
CCD
02F
02F
FC0
02F
02F
CCD
CCD
02F
02F
02F
02F
FC0
CCD
CCD
02F
02F
02F
02F
842
842
FC0
02F
02F
02F
02F
842
842
02F
02F
FC0
02F
02F
02F

//--- filelist.f
hdl/melee_pkg.sv
hdl/vga_if.sv
hdl/vga_raster.sv
hdl/frame_timer.sv
hdl/attack_ctrl.sv
hdl/wpn_draw_melee.sv
hdl/melee_top.sv
verification/melee_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = melee_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
